/* hdl/vga_timing_pkg.sv */
package vga_timing_pkg;

	// 640x480 at 60 Hz, 25 MHz pixel clock
	localparam int unsigned POS_W = 10;

	localparam logic [POS_W-1:0] H_TOTAL = 10'd800; // clocks per line
	localparam logic [POS_W-1:0] V_TOTAL = 10'd525; // lines per frame
	localparam logic [POS_W-1:0] H_LAST = H_TOTAL - 10'd1;
	localparam logic [POS_W-1:0] V_LAST = V_TOTAL - 10'd1;

	// sync pulses sit at the start of the line and frame, high while asserted
	localparam logic [POS_W-1:0] H_SYNC_LEN = 10'd96;
	localparam logic [POS_W-1:0] V_SYNC_LEN = 10'd2;

	// visible window, both ends inclusive
	localparam logic [POS_W-1:0] H_ACTIVE_START = 10'd144;
	localparam logic [POS_W-1:0] H_ACTIVE_END = 10'd783;
	localparam logic [POS_W-1:0] V_ACTIVE_START = 10'd35;
	localparam logic [POS_W-1:0] V_ACTIVE_END = 10'd514;

	// raster position, column and line
	typedef struct packed {
		logic [POS_W-1:0] h;
		logic [POS_W-1:0] v;
	} pix_pos_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
	} sync_t;

	// sync state at column 0 of line 0
	localparam sync_t SYNC_AT_ORIGIN = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

endpackage

/* hdl/card_pkg.sv */
package card_pkg;

	localparam int unsigned N_CARDS = 4; // one layer per card
	localparam int unsigned SLOT_W = $clog2(N_CARDS);

	// card size in active pixels
	localparam int unsigned CARD_W = 40;
	localparam int unsigned CARD_H = 60;

	// loader queue depth, also the host's starting credit count
	localparam int unsigned CREDITS = 4;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t BACKGROUND = '{red: 8'hC0, green: 8'hC0, blue: 8'hC0};
	localparam rgb_t BLANK = '{red: 8'h00, green: 8'h00, blue: 8'h00};

	// one card update from the host
	typedef struct packed {
		logic [SLOT_W-1:0] slot; // target layer
		logic enable;
		logic [9:0] x0; // active column of left edge
		logic [8:0] y0; // active row of top edge
		rgb_t colour;
	} card_desc_t;

	// per-layer result for one pixel
	typedef struct packed {
		logic hit;
		rgb_t colour;
	} layer_out_t;

endpackage

/* hdl/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing
	import vga_timing_pkg::*;
(
	input logic VGA_CLK_IN,
	input logic rst_n,
	output pix_pos_t pos,
	output sync_t sync
);

	logic [POS_W-1:0] h_cnt;
	logic [POS_W-1:0] v_cnt;
	logic h_active;
	logic v_active;

	// column counter, line counter steps on column wrap
	always_ff @(posedge VGA_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else
		begin
			if (h_cnt == H_LAST)
			begin
				h_cnt <= '0;
				if (v_cnt == V_LAST)
					v_cnt <= '0; // new frame
				else
					v_cnt <= v_cnt + 10'd1;
			end
			else
			begin
				h_cnt <= h_cnt + 10'd1;
			end
		end
	end

	assign pos.h = h_cnt;
	assign pos.v = v_cnt;

	assign h_active = (h_cnt >= H_ACTIVE_START) && (h_cnt <= H_ACTIVE_END);
	assign v_active = (v_cnt >= V_ACTIVE_START) && (v_cnt <= V_ACTIVE_END);

	// both pulses are active high
	always_comb
	begin
		sync.hsync = (h_cnt < H_SYNC_LEN);
		sync.vsync = (v_cnt < V_SYNC_LEN);
		sync.active = h_active && v_active;
	end

	a_h_in_range: assert property (
		@(posedge VGA_CLK_IN) disable iff (!rst_n)
		pos.h <= H_LAST
	) else $error("column counter ran past end of line: %0d", pos.h);

endmodule

/* hdl/card_loader.sv */
`timescale 1ns/1ps

module card_loader
	import vga_timing_pkg::*;
	import card_pkg::*;
(
	input logic VGA_CLK_IN,
	input logic rst_n,
	input card_desc_t desc_in,
	input logic desc_valid,
	input pix_pos_t pos,
	output logic credit_return,
	output card_desc_t wr_desc,
	output logic [N_CARDS-1:0] wr_en
);

	localparam int unsigned PTR_W = $clog2(CREDITS);
	localparam int unsigned CNT_W = $clog2(CREDITS + 1);

	card_desc_t q_mem [CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic push;
	logic pop;
	logic v_blank;

	assign full = (count == CNT_W'(CREDITS));
	assign push = desc_valid && !full; // host holds credit, so never full here

	// outside the visible lines, so nothing drawn this frame changes
	assign v_blank = (pos.v < V_ACTIVE_START) || (pos.v > V_ACTIVE_END);
	assign pop = v_blank && (count != '0);

	always_ff @(posedge VGA_CLK_IN)
	begin
		if (push)
			q_mem[wr_ptr] <= desc_in;
	end

	always_ff @(posedge VGA_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + PTR_W'(1);
			case ({push, pop})
				2'b10: count <= count + CNT_W'(1);
				2'b01: count <= count - CNT_W'(1);
				default: count <= count; // idle or both
			endcase
		end
	end

	// head entry goes straight onto the write bus
	assign wr_desc = q_mem[rd_ptr];
	assign wr_en = pop ? (N_CARDS'(1) << wr_desc.slot) : '0;
	assign credit_return = pop; // one credit per applied entry

	a_no_credit_overrun: assert property (
		@(posedge VGA_CLK_IN) disable iff (!rst_n)
		desc_valid |-> !full
	) else $error("descriptor sent without credit, queue full");

	a_wr_onehot: assert property (
		@(posedge VGA_CLK_IN) disable iff (!rst_n)
		$onehot0(wr_en)
	) else $error("more than one layer written at once: %b", wr_en);

endmodule

/* hdl/card_layer.sv */
`timescale 1ns/1ps

module card_layer
	import vga_timing_pkg::*;
	import card_pkg::*;
(
	input logic VGA_CLK_IN,
	input logic rst_n,
	input card_desc_t wr_desc,
	input logic wr_en,
	input pix_pos_t pos,
	output layer_out_t layer_out
);

	logic enable_q;
	logic [9:0] x0_q;
	logic [8:0] y0_q;
	rgb_t colour_q;

	logic [9:0] col;
	logic [9:0] row;
	logic [10:0] x_last;
	logic [9:0] y_last;
	logic in_window;
	logic in_card;

	always_ff @(posedge VGA_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			enable_q <= 1'b0; // cards start hidden
		else if (wr_en)
			enable_q <= wr_desc.enable;
	end

	always_ff @(posedge VGA_CLK_IN)
	begin
		if (wr_en)
		begin
			x0_q <= wr_desc.x0;
			y0_q <= wr_desc.y0;
			colour_q <= wr_desc.colour;
		end
	end

	// raster to active coordinates
	assign col = pos.h - H_ACTIVE_START;
	assign row = pos.v - V_ACTIVE_START;
	assign in_window = (pos.h >= H_ACTIVE_START) && (pos.h <= H_ACTIVE_END) &&
		(pos.v >= V_ACTIVE_START) && (pos.v <= V_ACTIVE_END);

	// extra bit so a card near the right edge cannot wrap
	assign x_last = {1'b0, x0_q} + 11'(CARD_W - 1);
	assign y_last = {1'b0, y0_q} + 10'(CARD_H - 1);

	assign in_card = ({1'b0, col} >= {1'b0, x0_q}) && ({1'b0, col} <= x_last) &&
		(row >= {1'b0, y0_q}) && (row <= y_last);

	always_ff @(posedge VGA_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			layer_out <= '{hit: 1'b0, colour: BLANK};
		else
			layer_out <= '{hit: enable_q && in_window && in_card, colour: colour_q};
	end

endmodule

/* hdl/card_compositor.sv */
`timescale 1ns/1ps

module card_compositor
	import vga_timing_pkg::*;
	import card_pkg::*;
(
	input logic VGA_CLK_IN,
	input logic rst_n,
	input layer_out_t layers [N_CARDS],
	input sync_t sync_in,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	sync_t sync_d1; // lines up with layer outputs
	sync_t sync_d2; // lines up with colour register
	rgb_t pick;
	rgb_t pix_next;
	rgb_t pix_q;

	always_ff @(posedge VGA_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_d1 <= SYNC_AT_ORIGIN;
			sync_d2 <= SYNC_AT_ORIGIN;
		end
		else
		begin
			sync_d1 <= sync_in;
			sync_d2 <= sync_d1;
		end
	end

	// lowest slot wins, so scan downwards and let it overwrite
	always_comb
	begin
		pick = BACKGROUND;
		for (int i = N_CARDS - 1; i >= 0; i--)
		begin
			if (layers[i].hit)
				pick = layers[i].colour;
		end
	end

	assign pix_next = sync_d1.active ? pick : BLANK; // black in porches and sync

	always_ff @(posedge VGA_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			pix_q <= BLANK;
		else
			pix_q <= pix_next;
	end

	assign hsync = sync_d2.hsync;
	assign vsync = sync_d2.vsync;
	assign red = pix_q.red;
	assign green = pix_q.green;
	assign blue = pix_q.blue;

	// colour and sync leave on the same pixel
	a_blank_outside_active: assert property (
		@(posedge VGA_CLK_IN) disable iff (!rst_n)
		!sync_d2.active |-> ({red, green, blue} == 24'h000000)
	) else $error("non-black colour %h outside active area", {red, green, blue});

	// no layer may hit while the pixel is in blanking
	a_no_hit_in_blank: assert property (
		@(posedge VGA_CLK_IN) disable iff (!rst_n)
		!sync_d1.active |-> (pick == BACKGROUND)
	) else $error("layer hit reported outside active area");

endmodule

/* hdl/card_display_top.sv */
`timescale 1ns/1ps

module card_display_top
	import vga_timing_pkg::*;
	import card_pkg::*;
(
	input logic VGA_CLK_IN,
	input logic rst_n,
	input card_desc_t desc_in,
	input logic desc_valid,
	output logic credit_return,
	output logic VGA_CLK_OUT,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	pix_pos_t pos;
	sync_t sync;
	card_desc_t wr_desc;
	logic [N_CARDS-1:0] wr_en;
	layer_out_t layer_outs [N_CARDS];

	assign VGA_CLK_OUT = VGA_CLK_IN; // DAC runs on the pixel clock

	vga_timing u_timing (
		.VGA_CLK_IN (VGA_CLK_IN),
		.rst_n (rst_n),
		.pos (pos),
		.sync (sync)
	);

	card_loader u_loader (
		.VGA_CLK_IN (VGA_CLK_IN),
		.rst_n (rst_n),
		.desc_in (desc_in),
		.desc_valid (desc_valid),
		.pos (pos),
		.credit_return (credit_return),
		.wr_desc (wr_desc),
		.wr_en (wr_en)
	);

	for (genvar i = 0; i < N_CARDS; i++)
	begin : g_layer
		card_layer u_layer (
			.VGA_CLK_IN (VGA_CLK_IN),
			.rst_n (rst_n),
			.wr_desc (wr_desc),
			.wr_en (wr_en[i]),
			.pos (pos),
			.layer_out (layer_outs[i])
		);
	end

	card_compositor u_compositor (
		.VGA_CLK_IN (VGA_CLK_IN),
		.rst_n (rst_n),
		.layers (layer_outs),
		.sync_in (sync),
		.hsync (hsync),
		.vsync (vsync),
		.red (red),
		.green (green),
		.blue (blue)
	);

endmodule

/* verif/card_display_tb.sv */
`timescale 1ns/1ps

module card_display_tb
	import vga_timing_pkg::*;
	import card_pkg::*;
;

	localparam int H_TOT = H_TOTAL;
	localparam int V_TOT = V_TOTAL;
	localparam int HA0 = H_ACTIVE_START;
	localparam int HA1 = H_ACTIVE_END;
	localparam int VA0 = V_ACTIVE_START;
	localparam int VA1 = V_ACTIVE_END;
	localparam int ACT_W = HA1 - HA0 + 1;
	localparam int ACT_H = VA1 - VA0 + 1;
	localparam int CW = CARD_W;
	localparam int CH = CARD_H;
	localparam int CRED = CREDITS;
	localparam int FRAME_CYCLES = H_TOT * V_TOT;
	localparam int WAIT_LIMIT = 2 * FRAME_CYCLES;
	localparam int N_ENTRIES = 7;
	localparam int N_BATCHES = 3;
	localparam int MAX_PROBES = 8;

	typedef struct packed {
		logic [9:0] col; // active column
		logic [9:0] row; // active row
		logic [23:0] exp;
	} probe_t;

	logic VGA_CLK_IN;
	logic rst_n;
	card_desc_t desc_in;
	logic desc_valid;
	logic credit_return;
	logic VGA_CLK_OUT;
	logic hsync;
	logic vsync;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	card_desc_t desc_tbl [N_ENTRIES];
	int entry_batch [N_ENTRIES];
	int n_probes [N_ENTRIES];
	probe_t probe_tbl [N_ENTRIES * MAX_PROBES];
	logic [23:0] frame_buf [ACT_W * ACT_H];

	// raster as seen on the output pins
	int trk_line = 0;
	int trk_col = 0;
	bit trk_locked = 1'b0;
	bit trk_sof = 1'b0;
	bit prev_hs = 1'b1;
	bit prev_vs = 1'b1;
	bit hs_rise;
	bit vs_rise;
	bit smp_hs;
	bit smp_vs;
	bit smp_credit;
	logic [23:0] smp_rgb;

	int credits;
	int errors;
	int tests_run;
	int tests_failed;
	bit timed_out;

	card_display_top dut (
		.VGA_CLK_IN (VGA_CLK_IN),
		.rst_n (rst_n),
		.desc_in (desc_in),
		.desc_valid (desc_valid),
		.credit_return (credit_return),
		.VGA_CLK_OUT (VGA_CLK_OUT),
		.hsync (hsync),
		.vsync (vsync),
		.red (red),
		.green (green),
		.blue (blue)
	);

	always #2 VGA_CLK_IN = ~VGA_CLK_IN;

	// outputs settle after the rising edge, so sample on the falling one
	always @(negedge VGA_CLK_IN)
	begin
		hs_rise = hsync && !prev_hs;
		vs_rise = vsync && !prev_vs;
		if (hs_rise)
		begin
			trk_col = 0;
			if (vs_rise)
			begin
				trk_line = 0;
				trk_locked = 1'b1;
			end
			else
				trk_line = trk_line + 1;
		end
		else
			trk_col = trk_col + 1;
		trk_sof = hs_rise && vs_rise;
		prev_hs = hsync;
		prev_vs = vsync;
		smp_hs = hsync;
		smp_vs = vsync;
		smp_credit = credit_return;
		smp_rgb = {red, green, blue};
	end

	// DAC clock follows the pixel clock, checked mid half-period
	always @(VGA_CLK_IN)
	begin
		#1;
		assert (VGA_CLK_OUT === VGA_CLK_IN)
		else report_int("VGA_CLK_OUT", VGA_CLK_IN, VGA_CLK_OUT);
	end

	task automatic report_int(input string sig, input int exp, input int got);
		errors++;
		$display("Mismatch at time %0t: %s expected %0d got %0d", $time, sig, exp, got);
	endtask

	task automatic report_rgb(input string sig, input logic [23:0] exp, input logic [23:0] got);
		errors++;
		$display("Mismatch at time %0t: %s expected %h got %h", $time, sig, exp, got);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Error at time %0t: gave up waiting for %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge VGA_CLK_IN);
		if (smp_credit)
			credits++;
	endtask

	function automatic logic [23:0] pick_colour(input int idx);
		logic [23:0] c;
		c = $urandom;
		c[23:22] = 2'b01; // never gray, never black
		c[1:0] = idx[1:0];
		return c;
	endfunction

	task automatic set_entry(input int i, input int slot, input bit en, input int x, input int y,
		input logic [23:0] c, input int batch);
		card_desc_t d;
		d.slot = slot[SLOT_W-1:0];
		d.enable = en;
		d.x0 = x[9:0];
		d.y0 = y[8:0];
		d.colour = c;
		desc_tbl[i] = d;
		entry_batch[i] = batch;
		n_probes[i] = 0;
	endtask

	task automatic add_probe(input int i, input int col, input int row, input logic [23:0] exp);
		probe_t p;
		p.col = col[9:0];
		p.row = row[9:0];
		p.exp = exp;
		probe_tbl[i * MAX_PROBES + n_probes[i]] = p;
		n_probes[i]++;
	endtask

	task automatic build_table();
		int x;
		int y;
		logic [23:0] c;
		logic [23:0] c0;
		logic [23:0] c1;
		// one card per quadrant, so edges never touch another card
		for (int k = 0; k < CRED; k++)
		begin
			x = (k % 2) * (ACT_W / 2) + 1 + $urandom % 278;
			y = (k / 2) * (ACT_H / 2) + 1 + $urandom % 178;
			c = pick_colour(k);
			set_entry(k, k, 1'b1, x, y, c, 0);
			add_probe(k, x, y, c);
			add_probe(k, x + CW - 1, y, c);
			add_probe(k, x, y + CH - 1, c);
			add_probe(k, x + CW - 1, y + CH - 1, c);
			add_probe(k, x - 1, y, BACKGROUND);
			add_probe(k, x + CW, y, BACKGROUND);
			add_probe(k, x, y - 1, BACKGROUND);
			add_probe(k, x, y + CH, BACKGROUND);
		end
		// slot 0 overlaps the lower right part of slot 1
		x = 1 + $urandom % 200;
		y = 1 + $urandom % 120;
		c1 = pick_colour(4);
		c0 = pick_colour(5);
		set_entry(4, 1, 1'b1, x, y, c1, 1);
		add_probe(4, x, y, c1);
		add_probe(4, x, y + CH - 1, c1);
		add_probe(4, x + CW - 1, y + 29, c1);
		add_probe(4, x - 1, y, BACKGROUND);
		add_probe(4, x, y - 1, BACKGROUND);
		set_entry(5, 0, 1'b1, x + 20, y + 30, c0, 1);
		add_probe(5, x + 20, y + 30, c0); // overlap
		add_probe(5, x + CW - 1, y + CH - 1, c0);
		add_probe(5, x + CW, y + 30, c0);
		add_probe(5, x + 59, y + 89, c0);
		add_probe(5, x + 60, y + 89, BACKGROUND);
		add_probe(5, x + 59, y + 90, BACKGROUND);
		add_probe(5, x + 19, y + 30, c1);
		set_entry(6, 0, 1'b0, x + 20, y + 30, c0, 2);
		add_probe(6, x + 20, y + 30, c1); // slot 1 shows through
		add_probe(6, x + CW - 1, y + CH - 1, c1);
		add_probe(6, x + CW, y + 30, BACKGROUND);
		add_probe(6, x + 59, y + 89, BACKGROUND);
	endtask

	task automatic wait_line(input int line);
		int n;
		n = 0;
		while (!(trk_locked && trk_line == line) && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		assert (trk_locked && trk_line == line)
		else report_timeout($sformatf("output line %0d", line));
	endtask

	task automatic wait_credits();
		int n;
		n = 0;
		while (credits != CRED && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		assert (credits == CRED) else report_timeout("all credits to return");
	endtask

	task automatic send_batch(input int b);
		for (int i = 0; i < N_ENTRIES; i++)
		begin
			if (entry_batch[i] == b)
			begin
				assert (credits > 0)
				else
				begin
					errors++;
					$display("Error at time %0t: no credit left to send entry %0d", $time, i);
				end
				if (credits > 0)
				begin
					#1;
					desc_in = desc_tbl[i];
					desc_valid = 1'b1;
					credits--;
					next_cycle();
				end
			end
		end
		#1;
		desc_valid = 1'b0;
		desc_in = '0;
	endtask

	// credit_return follows the counters, two clocks ahead of the pins
	task automatic check_credit_window();
		int n;
		int pulses;
		int line;
		bit left;
		bit done;
		bit in_act;
		n = 0;
		pulses = 0;
		left = 1'b0;
		done = 1'b0;
		while (!done && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
			line = (trk_col + 2 >= H_TOT) ? (trk_line + 1) % V_TOT : trk_line;
			in_act = (line >= VA0) && (line <= VA1);
			if (in_act && left)
				done = 1'b1;
			else if (in_act)
			begin
				assert (!smp_credit) else report_int("credit_return on active line", 0, 1);
			end
			else
			begin
				left = 1'b1;
				if (smp_credit)
					pulses++;
			end
		end
		assert (done) else report_timeout("the next active line after blanking");
		if (done)
		begin
			assert (pulses == CRED) else report_int("credit_return pulses", CRED, pulses);
			assert (credits == CRED) else report_int("host credit count", CRED, credits);
		end
	endtask

	task automatic capture_frame();
		int n;
		int hs_cnt;
		int vs_cnt;
		bit found;
		found = 1'b0;
		n = 0;
		while (!found && n < WAIT_LIMIT)
		begin
			next_cycle();
			found = trk_sof;
			n++;
		end
		assert (found) else report_timeout("a rising edge of vsync");
		hs_cnt = 0;
		vs_cnt = 0;
		for (n = 0; n < FRAME_CYCLES && found; n++)
		begin
			if (n > 0)
				next_cycle();
			hs_cnt += smp_hs;
			vs_cnt += smp_vs;
			if (trk_col == H_TOT - 1)
			begin
				assert (hs_cnt == H_SYNC_LEN) else report_int("hsync high cycles", H_SYNC_LEN, hs_cnt);
				hs_cnt = 0;
			end
			if (trk_line >= VA0 && trk_line <= VA1 && trk_col >= HA0 && trk_col <= HA1)
				frame_buf[(trk_line - VA0) * ACT_W + trk_col - HA0] = smp_rgb;
			else
				assert (smp_rgb == BLANK) else report_rgb("rgb in blanking", BLANK, smp_rgb);
		end
		if (found)
		begin
			assert (trk_line == V_TOT - 1 && trk_col == H_TOT - 1)
			else
			begin
				errors++;
				$display("Error at time %0t: frame ended at line %0d column %0d", $time,
					trk_line, trk_col);
			end
			assert (vs_cnt == V_SYNC_LEN * H_TOT)
			else report_int("vsync high cycles", V_SYNC_LEN * H_TOT, vs_cnt);
		end
	endtask

	task automatic check_probes(input int i);
		probe_t pr;
		logic [23:0] got;
		for (int p = 0; p < n_probes[i]; p++)
		begin
			pr = probe_tbl[i * MAX_PROBES + p];
			got = frame_buf[pr.row * ACT_W + pr.col];
			assert (got == pr.exp)
			else report_rgb($sformatf("rgb of entry %0d at column %0d row %0d", i, pr.col, pr.row),
				pr.exp, got);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	function automatic string batch_name(input int b);
		case (b)
			0: return "placement_and_credits";
			1: return "priority_overlap";
			default: return "priority_disable";
		endcase
	endfunction

	initial
	begin
		int err0;
		VGA_CLK_IN = 1'b0;
		rst_n = 1'b0;
		desc_in = '0;
		desc_valid = 1'b0;
		credits = CRED;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		void'($urandom(32'ha2894fb3));
		build_table();
		repeat (3) @(posedge VGA_CLK_IN);
		#1;
		rst_n = 1'b1;

		// no card enabled yet
		err0 = errors;
		capture_frame();
		if (!timed_out)
		begin
			for (int k = 0; k < ACT_W * ACT_H; k++)
				assert (frame_buf[k] == BACKGROUND)
				else report_rgb($sformatf("rgb at column %0d row %0d", k % ACT_W, k / ACT_W),
					BACKGROUND, frame_buf[k]);
		end
		end_test("sync_blank_background", err0);

		for (int b = 0; b < N_BATCHES && !timed_out; b++)
		begin
			err0 = errors;
			if (b == 0)
			begin
				wait_line(100); // well inside the visible lines
				if (!timed_out)
				begin
					send_batch(b);
					check_credit_window();
				end
			end
			else
			begin
				send_batch(b);
				wait_credits();
			end
			if (!timed_out)
				capture_frame();
			for (int i = 0; i < N_ENTRIES && !timed_out; i++)
				if (entry_batch[i] == b)
					check_probes(i);
			end_test(batch_name(b), err0);
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
hdl/vga_timing_pkg.sv
hdl/card_pkg.sv
hdl/vga_timing.sv
hdl/card_loader.sv
hdl/card_layer.sv
hdl/card_compositor.sv
hdl/card_display_top.sv
verif/card_display_tb.sv

/* Bender.yml */
package:
  name: card_display

sources:
  - hdl/vga_timing_pkg.sv
  - hdl/card_pkg.sv
  - hdl/vga_timing.sv
  - hdl/card_loader.sv
  - hdl/card_layer.sv
  - hdl/card_compositor.sv
  - hdl/card_display_top.sv
  - target: simulation
    files:
      - verif/card_display_tb.sv
